// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log for the pass line
rm -f sim.log \
	&& verilator --binary --timing --top-module tb_core_shell -f verilog.f -o tb_core_shell_sim \
	&& ./obj_dir/tb_core_shell_sim > sim.log 2>&1
test -f sim.log && cat sim.log
grep -q "^Test passed$" sim.log && echo "run_sim: PASS" || { echo "run_sim: FAIL"; exit 1; }

// File: source/arcade_cfg.svh
// Build-time constants shared by the arcade shell
// Download indices follow the host loader numbering and must not be reused
// Divider ratios assume a 96 MHz system clock and a 4-bit enable counter
// The output color width must stay above the input width by at most the input width
`ifndef ARCADE_CFG_SVH
`define ARCADE_CFG_SVH

// Index that carries the ROM image during a download
`define CFG_ROM_INDEX 0
// Index that carries the title number chosen in the menu
`define CFG_TNO_INDEX 1
// Index that carries the DIP switch bytes
`define CFG_DIP_INDEX 254

// Number of DIP switch bytes kept by the board
`define CFG_DIP_COUNT 3
// Factory DIP settings, held until the host sends its own
`define CFG_DIP0_DEFAULT 8'hFC
`define CFG_DIP1_DEFAULT 8'hFC
`define CFG_DIP2_DEFAULT 8'h0F

// The first title is selected when no title number arrives
`define CFG_TNO_DEFAULT 4'd1

// System clocks per 24 MHz main enable
`define CFG_CE_MAIN_DIV 4
// System clocks per 6 MHz pixel enable
`define CFG_CE_PIX_DIV 16

// Color component widths from the game board and towards the scaler
`define CFG_COLOR_IN_W 6
`define CFG_COLOR_OUT_W 8

`endif

// File: source/arcade_pkg.sv
// Types shared by every block of the arcade shell
// Color widths come from the config header, all other widths are fixed by the host
`include "arcade_cfg.svh"

package arcade_pkg;

	//////////////////////////////////////////////////////////////////////
	// Host download stream
	//////////////////////////////////////////////////////////////////////

	// Selects what the current download carries
	typedef logic [15:0] ioctl_index_t;
	// Byte address within the download, it steps by 2 in 16-bit mode
	typedef logic [26:0] ioctl_addr_t;
	// One 16-bit word of download data
	typedef logic [15:0] ioctl_data_t;

	// One bank of DIP switches
	typedef logic [7:0] dip_t;
	// Title number, 1 for the first title and 2 for the second
	typedef logic [3:0] tno_t;

	//////////////////////////////////////////////////////////////////////
	// Player controls
	//////////////////////////////////////////////////////////////////////

	// Raw joystick word as the host sends it, active high
	typedef logic [31:0] joy_t;
	// Active-low group in the order start, button 3, button 2, button 1,
	// down, up, right, left from the top bit down
	typedef logic [7:0] player_t;
	// One active-low bit per player, player 1 in bit 0
	typedef logic [3:0] group4_t;

	//////////////////////////////////////////////////////////////////////
	// Video and timing
	//////////////////////////////////////////////////////////////////////

	// Color component as the game board drives it
	typedef logic [`CFG_COLOR_IN_W-1:0] color_in_t;
	// Color component towards the scaler
	typedef logic [`CFG_COLOR_OUT_W-1:0] color_out_t;

	// State of the clock enable divider
	typedef logic [3:0] cediv_t;

endpackage

// File: source/clock_enables.sv
// Clock enables for the 96 MHz system clock
// ce_main pulses one cycle in four, ce_pix one cycle in sixteen
// Both enables fall on the same counter phase so they stay aligned
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module clock_enables (
	input  logic clk_sys,
	input  logic rst,
	output logic ce_main,
	output logic ce_pix
);

	// Divider ratios are powers of two, so a mask picks the main phase
	localparam arcade_pkg::cediv_t main_last = arcade_pkg::cediv_t'(`CFG_CE_MAIN_DIV - 1);
	localparam arcade_pkg::cediv_t pix_last  = arcade_pkg::cediv_t'(`CFG_CE_PIX_DIV - 1);

	arcade_pkg::cediv_t div_cnt;

	// Free-running counter that wraps after 16 system clocks
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + arcade_pkg::cediv_t'(1);
		end
	end

	// Main enable at phases 3, 7, 11 and 15
	assign ce_main = (div_cnt & main_last) == main_last;
	// Pixel enable on the last phase, which is also a main phase
	assign ce_pix = div_cnt == pix_last;

endmodule

// File: source/core_shell.sv
// Platform glue around the arcade board
// Timing and colors from the board come in as plain inputs
// Download writes are single-cycle strobes and are never stalled
`timescale 1ns/1ps

module core_shell (
	input  logic                      clk_sys,
	input  logic                      rst,
	// Host download stream
	input  logic                      download,
	input  logic                      download_wr,
	input  arcade_pkg::ioctl_index_t  download_index,
	input  arcade_pkg::ioctl_addr_t   download_addr,
	input  arcade_pkg::ioctl_data_t   download_data,
	// Host joysticks
	input  arcade_pkg::joy_t          joy_0,
	input  arcade_pkg::joy_t          joy_1,
	input  arcade_pkg::joy_t          joy_2,
	input  arcade_pkg::joy_t          joy_3,
	// Board video
	input  arcade_pkg::color_in_t     r_in,
	input  arcade_pkg::color_in_t     g_in,
	input  arcade_pkg::color_in_t     b_in,
	input  logic                      n_hsync,
	input  logic                      n_vsync,
	input  logic                      n_hblank,
	input  logic                      n_vblank,
	// Board settings
	output arcade_pkg::dip_t          dip_0,
	output arcade_pkg::dip_t          dip_1,
	output arcade_pkg::dip_t          dip_2,
	output arcade_pkg::tno_t          tno,
	output logic                      rom_load,
	// Board inputs
	output arcade_pkg::player_t       p1,
	output arcade_pkg::player_t       p2,
	output arcade_pkg::player_t       p3,
	output arcade_pkg::player_t       p4,
	output arcade_pkg::group4_t       coin,
	output arcade_pkg::group4_t       service,
	// Clock enables
	output logic                      ce_main,
	output logic                      ce_pix,
	// Scaler video
	output arcade_pkg::color_out_t    vga_r,
	output arcade_pkg::color_out_t    vga_g,
	output arcade_pkg::color_out_t    vga_b,
	output logic                      vga_hs,
	output logic                      vga_vs,
	output logic                      vga_de
);

	//////////////////////////////////////////////////////////////////////
	// Download stream, driven from the host ports
	//////////////////////////////////////////////////////////////////////

	download_if dl ();

	assign dl.wr    = download_wr;
	assign dl.index = download_index;
	assign dl.addr  = download_addr;
	assign dl.data  = download_data;

	//////////////////////////////////////////////////////////////////////
	// Input side
	//////////////////////////////////////////////////////////////////////

	ioctl_capture i_capture (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.download (download),
		.dl       (dl.sink),
		.dip_0    (dip_0),
		.dip_1    (dip_1),
		.dip_2    (dip_2),
		.tno      (tno),
		.rom_load (rom_load)
	);

	player_inputs i_inputs (
		.clk_sys (clk_sys),
		.rst     (rst),
		.joy_0   (joy_0),
		.joy_1   (joy_1),
		.joy_2   (joy_2),
		.joy_3   (joy_3),
		.p1      (p1),
		.p2      (p2),
		.p3      (p3),
		.p4      (p4),
		.coin    (coin),
		.service (service)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock enables and video output
	//////////////////////////////////////////////////////////////////////

	clock_enables i_enables (
		.clk_sys (clk_sys),
		.rst     (rst),
		.ce_main (ce_main),
		.ce_pix  (ce_pix)
	);

	// The pixel enable also leaves the shell for the scaler
	video_conditioner i_video (
		.clk_sys  (clk_sys),
		.rst      (rst),
		.ce_pix   (ce_pix),
		.r_in     (r_in),
		.g_in     (g_in),
		.b_in     (b_in),
		.n_hsync  (n_hsync),
		.n_vsync  (n_vsync),
		.n_hblank (n_hblank),
		.n_vblank (n_vblank),
		.vga_r    (vga_r),
		.vga_g    (vga_g),
		.vga_b    (vga_b),
		.vga_hs   (vga_hs),
		.vga_vs   (vga_vs),
		.vga_de   (vga_de)
	);

endmodule

// File: source/download_if.sv
// Download stream from the host loader
// A write is valid only in the cycle where wr is high and it is never stalled
`timescale 1ns/1ps

interface download_if;

	// Single-cycle write strobe
	logic                     wr;
	// What the download carries
	arcade_pkg::ioctl_index_t index;
	// Byte address of the word on data
	arcade_pkg::ioctl_addr_t  addr;
	// Write data, only sampled while wr is high
	arcade_pkg::ioctl_data_t  data;

	// The loader side drives the stream
	modport host (
		output wr,
		output index,
		output addr,
		output data
	);

	// Consumers only watch the stream
	modport sink (
		input wr,
		input index,
		input addr,
		input data
	);

endinterface

// File: source/ioctl_capture.sv
// Captures board settings from the host download stream
// DIP bytes and title number appear one cycle after their write strobe
// rom_load is combinational and follows download and the index directly
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module ioctl_capture (
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                download,
	download_if.sink            dl,
	output arcade_pkg::dip_t    dip_0,
	output arcade_pkg::dip_t    dip_1,
	output arcade_pkg::dip_t    dip_2,
	output arcade_pkg::tno_t    tno,
	output logic                rom_load
);

	// DIP bank, one byte per download address
	arcade_pkg::dip_t dip_bank [`CFG_DIP_COUNT];
	arcade_pkg::tno_t tno_reg;

	// Write decodes
	logic dip_hit;
	logic tno_hit;

	// Only the first few addresses of the DIP index map to real switches
	assign dip_hit = dl.wr
		&& (dl.index == arcade_pkg::ioctl_index_t'(`CFG_DIP_INDEX))
		&& (dl.addr < arcade_pkg::ioctl_addr_t'(`CFG_DIP_COUNT));

	// The title number arrives as a single write on its own index
	assign tno_hit = dl.wr && (dl.index == arcade_pkg::ioctl_index_t'(`CFG_TNO_INDEX));

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			dip_bank[0] <= `CFG_DIP0_DEFAULT;
			dip_bank[1] <= `CFG_DIP1_DEFAULT;
			dip_bank[2] <= `CFG_DIP2_DEFAULT;
		end else if (dip_hit) begin
			// Address is known to be below the bank size here
			dip_bank[dl.addr[1:0]] <= dl.data[7:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			tno_reg <= `CFG_TNO_DEFAULT;
		end else if (tno_hit) begin
			tno_reg <= dl.data[3:0];
		end
	end

	assign dip_0 = dip_bank[0];
	assign dip_1 = dip_bank[1];
	assign dip_2 = dip_bank[2];
	assign tno   = tno_reg;

	// ROM data is only accepted while a download on the ROM index is active
	assign rom_load = download && (dl.index == arcade_pkg::ioctl_index_t'(`CFG_ROM_INDEX));

endmodule

// File: source/player_inputs.sv
// Remaps host joystick words into the active-low input groups of the board
// Every output is registered and reads all ones (nothing pressed) after reset
`timescale 1ns/1ps

module player_inputs (
	input  logic                 clk_sys,
	input  logic                 rst,
	input  arcade_pkg::joy_t     joy_0,
	input  arcade_pkg::joy_t     joy_1,
	input  arcade_pkg::joy_t     joy_2,
	input  arcade_pkg::joy_t     joy_3,
	output arcade_pkg::player_t  p1,
	output arcade_pkg::player_t  p2,
	output arcade_pkg::player_t  p3,
	output arcade_pkg::player_t  p4,
	output arcade_pkg::group4_t  coin,
	output arcade_pkg::group4_t  service
);

	// Host order is right, left, down, up, then buttons and start in bits 7:4
	// The board wants start and buttons on top, then down, up, right, left
	function automatic arcade_pkg::player_t remap(input arcade_pkg::joy_t joy);
		return ~{joy[7:4], joy[2], joy[3], joy[0], joy[1]};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			p1      <= '1;
			p2      <= '1;
			p3      <= '1;
			p4      <= '1;
			coin    <= '1;
			service <= '1;
		end else begin
			p1 <= remap(joy_0);
			p2 <= remap(joy_1);
			p3 <= remap(joy_2);
			p4 <= remap(joy_3);
			// Coin and service share one group each, player 1 in the low bit
			coin    <= ~{joy_3[8], joy_2[8], joy_1[8], joy_0[8]};
			service <= ~{joy_3[9], joy_2[9], joy_1[9], joy_0[9]};
		end
	end

endmodule

// File: source/video_conditioner.sv
// Conditions the board video for the scaler
// Outputs change only on a pixel enable and hold in between
// Colors are not blanked, the scaler masks them with de
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module video_conditioner (
	input  logic                    clk_sys,
	input  logic                    rst,
	input  logic                    ce_pix,
	input  arcade_pkg::color_in_t   r_in,
	input  arcade_pkg::color_in_t   g_in,
	input  arcade_pkg::color_in_t   b_in,
	input  logic                    n_hsync,
	input  logic                    n_vsync,
	input  logic                    n_hblank,
	input  logic                    n_vblank,
	output arcade_pkg::color_out_t  vga_r,
	output arcade_pkg::color_out_t  vga_g,
	output arcade_pkg::color_out_t  vga_b,
	output logic                    vga_hs,
	output logic                    vga_vs,
	output logic                    vga_de
);

	// Number of low bits that have to be filled in
	localparam int pad_w = `CFG_COLOR_OUT_W - `CFG_COLOR_IN_W;

	// Repeating the top bits below the color keeps full white at all ones
	function automatic arcade_pkg::color_out_t widen(input arcade_pkg::color_in_t c);
		return {c, c[`CFG_COLOR_IN_W-1 -: pad_w]};
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
			vga_de <= 1'b0;
		end else if (ce_pix) begin
			vga_r <= widen(r_in);
			vga_g <= widen(g_in);
			vga_b <= widen(b_in);
			// The board drives active-low syncs, the scaler wants them high
			vga_hs <= ~n_hsync;
			vga_vs <= ~n_vsync;
			// Active picture only while neither blank is asserted
			vga_de <= n_hblank & n_vblank;
		end
	end

endmodule

// File: testbench/shell_checker.sv
// Reference model and scoreboard for the arcade shell
// Model registers update on the rising edge and are compared on the falling edge
// Expected values come from the shell rules and never from the DUT outputs
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module shell_checker (
	input  logic                      clk_sys,
	input  logic                      rst,
	input  logic                      download,
	input  logic                      download_wr,
	input  arcade_pkg::ioctl_index_t  download_index,
	input  arcade_pkg::ioctl_addr_t   download_addr,
	input  arcade_pkg::ioctl_data_t   download_data,
	input  arcade_pkg::joy_t          joy_0,
	input  arcade_pkg::joy_t          joy_1,
	input  arcade_pkg::joy_t          joy_2,
	input  arcade_pkg::joy_t          joy_3,
	input  arcade_pkg::color_in_t     r_in,
	input  arcade_pkg::color_in_t     g_in,
	input  arcade_pkg::color_in_t     b_in,
	input  logic                      n_hsync,
	input  logic                      n_vsync,
	input  logic                      n_hblank,
	input  logic                      n_vblank,
	input  arcade_pkg::dip_t          dip_0,
	input  arcade_pkg::dip_t          dip_1,
	input  arcade_pkg::dip_t          dip_2,
	input  arcade_pkg::tno_t          tno,
	input  logic                      rom_load,
	input  arcade_pkg::player_t       p1,
	input  arcade_pkg::player_t       p2,
	input  arcade_pkg::player_t       p3,
	input  arcade_pkg::player_t       p4,
	input  arcade_pkg::group4_t       coin,
	input  arcade_pkg::group4_t       service,
	input  logic                      ce_main,
	input  logic                      ce_pix,
	input  arcade_pkg::color_out_t    vga_r,
	input  arcade_pkg::color_out_t    vga_g,
	input  arcade_pkg::color_out_t    vga_b,
	input  logic                      vga_hs,
	input  logic                      vga_vs,
	input  logic                      vga_de,
	output int                        value_errors,
	output int                        other_errors,
	output int                        check_count
);

	// Model state stays X until the first reset edge
	logic        model_valid;
	logic [7:0]  dip0_m;
	logic [7:0]  dip1_m;
	logic [7:0]  dip2_m;
	logic [3:0]  tno_m;
	logic [7:0]  p1_m;
	logic [7:0]  p2_m;
	logic [7:0]  p3_m;
	logic [7:0]  p4_m;
	logic [3:0]  coin_m;
	logic [3:0]  service_m;
	logic [3:0]  phase_m;
	logic [7:0]  vr_m;
	logic [7:0]  vg_m;
	logic [7:0]  vb_m;
	logic        hs_m;
	logic        vs_m;
	logic        de_m;
	// Pixel enable spacing
	int          since_rst;
	int          last_pix;
	logic        pix_seen;

	// Board order from the top bit is start, buttons 3 to 1, down, up, right and left
	function automatic logic [7:0] board_player(input logic [31:0] joy);
		logic [7:0] grp;
		grp[7] = ~joy[7];
		grp[6] = ~joy[6];
		grp[5] = ~joy[5];
		grp[4] = ~joy[4];
		grp[3] = ~joy[2];
		grp[2] = ~joy[3];
		grp[1] = ~joy[0];
		grp[0] = ~joy[1];
		return grp;
	endfunction

	// Bit n of the group belongs to player n+1 and is low while pressed
	function automatic logic [3:0] board_group(input int bit_pos, input logic [31:0] j0,
			input logic [31:0] j1, input logic [31:0] j2, input logic [31:0] j3);
		logic [3:0] grp;
		grp[0] = ~j0[bit_pos];
		grp[1] = ~j1[bit_pos];
		grp[2] = ~j2[bit_pos];
		grp[3] = ~j3[bit_pos];
		return grp;
	endfunction

	// The two top bits fill the new low bits
	function automatic logic [7:0] widen_color(input logic [5:0] c);
		return {c, c[5:4]};
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		if (rst) begin
			model_valid <= 1'b1;
			dip0_m      <= `CFG_DIP0_DEFAULT;
			dip1_m      <= `CFG_DIP1_DEFAULT;
			dip2_m      <= `CFG_DIP2_DEFAULT;
			tno_m       <= `CFG_TNO_DEFAULT;
			p1_m        <= 8'hFF;
			p2_m        <= 8'hFF;
			p3_m        <= 8'hFF;
			p4_m        <= 8'hFF;
			coin_m      <= 4'hF;
			service_m   <= 4'hF;
			phase_m     <= 4'd0;
			vr_m        <= 8'd0;
			vg_m        <= 8'd0;
			vb_m        <= 8'd0;
			hs_m        <= 1'b0;
			vs_m        <= 1'b0;
			de_m        <= 1'b0;
		end else begin
			// Only DIP addresses 0 to 2 exist and anything else is dropped
			if (download_wr && download_index == 16'd254) begin
				if (download_addr == 27'd0)
					dip0_m <= download_data[7:0];
				if (download_addr == 27'd1)
					dip1_m <= download_data[7:0];
				if (download_addr == 27'd2)
					dip2_m <= download_data[7:0];
			end
			if (download_wr && download_index == 16'd1)
				tno_m <= download_data[3:0];
			p1_m      <= board_player(joy_0);
			p2_m      <= board_player(joy_1);
			p3_m      <= board_player(joy_2);
			p4_m      <= board_player(joy_3);
			coin_m    <= board_group(8, joy_0, joy_1, joy_2, joy_3);
			service_m <= board_group(9, joy_0, joy_1, joy_2, joy_3);
			phase_m   <= phase_m + 4'd1;
			// Video is captured only on the last divider phase
			if (phase_m == 4'd15) begin
				vr_m <= widen_color(r_in);
				vg_m <= widen_color(g_in);
				vb_m <= widen_color(b_in);
				hs_m <= ~n_hsync;
				vs_m <= ~n_vsync;
				de_m <= n_hblank & n_vblank;
			end
		end
	end

	// First pixel enable after 16 cycles out of reset, then one every 16 cycles
	always @(posedge clk_sys) begin : pix_spacing
		int count;
		if (rst) begin
			since_rst <= 0;
			pix_seen  <= 1'b0;
		end else begin
			count = since_rst + 1;
			since_rst <= count;
			if (ce_pix) begin
				if (!pix_seen && count != `CFG_CE_PIX_DIV) begin
					other_errors++;
					$display("First pixel enable came %0d cycles after reset instead of %0d",
						count, `CFG_CE_PIX_DIV);
				end else if (pix_seen && count - last_pix != `CFG_CE_PIX_DIV) begin
					other_errors++;
					$display("Pixel enables came %0d cycles apart instead of %0d",
						count - last_pix, `CFG_CE_PIX_DIV);
				end
				last_pix <= count;
				pix_seen <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs are compared on the falling edge where every one is settled
	//////////////////////////////////////////////////////////////////////

	always @(negedge clk_sys) begin
		if (model_valid === 1'b1) begin
			compare("dip_0", 32'(dip0_m), 32'(dip_0));
			compare("dip_1", 32'(dip1_m), 32'(dip_1));
			compare("dip_2", 32'(dip2_m), 32'(dip_2));
			compare("tno", 32'(tno_m), 32'(tno));
			compare("rom_load", 32'(download && download_index == 16'd0), 32'(rom_load));
			compare("p1", 32'(p1_m), 32'(p1));
			compare("p2", 32'(p2_m), 32'(p2));
			compare("p3", 32'(p3_m), 32'(p3));
			compare("p4", 32'(p4_m), 32'(p4));
			compare("coin", 32'(coin_m), 32'(coin));
			compare("service", 32'(service_m), 32'(service));
			compare("ce_main", 32'(phase_m[1:0] == 2'd3), 32'(ce_main));
			compare("ce_pix", 32'(phase_m == 4'd15), 32'(ce_pix));
			compare("vga_r", 32'(vr_m), 32'(vga_r));
			compare("vga_g", 32'(vg_m), 32'(vga_g));
			compare("vga_b", 32'(vb_m), 32'(vga_b));
			compare("vga_hs", 32'(hs_m), 32'(vga_hs));
			compare("vga_vs", 32'(vs_m), 32'(vga_vs));
			compare("vga_de", 32'(de_m), 32'(vga_de));
		end
	end

endmodule

// File: testbench/tb_core_shell.sv
// Testbench for the arcade shell
// Rows of a stimulus table drive download writes, joystick loads and video pixels
// Random joystick words and colors come from a 16-bit Galois LFSR
`timescale 1ns/1ps
`include "arcade_cfg.svh"

module tb_core_shell;

	localparam int clk_period = 40;
	localparam int row_count = 24;
	// A pixel row may wait a whole enable period plus its setup and capture cycles
	localparam int row_wait = `CFG_CE_PIX_DIV + 4;
	localparam int watchdog_cycles = 5 + row_count * row_wait + 40;

	localparam logic [1:0] op_dl = 2'd0;
	localparam logic [1:0] op_joy = 2'd1;
	localparam logic [1:0] op_pix = 2'd2;

	// ctl is the download level for a write, or hsync, vsync, hblank, vblank for a pixel
	typedef struct packed {
		logic [1:0]  op;
		logic        rnd;
		logic [3:0]  ctl;
		logic [15:0] index;
		logic [26:0] addr;
		logic [15:0] data;
	} row_t;

	logic clk_sys = 1'b0;
	logic rst;
	logic download;
	logic download_wr;
	arcade_pkg::ioctl_index_t download_index;
	arcade_pkg::ioctl_addr_t download_addr;
	arcade_pkg::ioctl_data_t download_data;
	arcade_pkg::joy_t joy_0;
	arcade_pkg::joy_t joy_1;
	arcade_pkg::joy_t joy_2;
	arcade_pkg::joy_t joy_3;
	arcade_pkg::color_in_t r_in;
	arcade_pkg::color_in_t g_in;
	arcade_pkg::color_in_t b_in;
	logic n_hsync;
	logic n_vsync;
	logic n_hblank;
	logic n_vblank;
	arcade_pkg::dip_t dip_0;
	arcade_pkg::dip_t dip_1;
	arcade_pkg::dip_t dip_2;
	arcade_pkg::tno_t tno;
	logic rom_load;
	arcade_pkg::player_t p1;
	arcade_pkg::player_t p2;
	arcade_pkg::player_t p3;
	arcade_pkg::player_t p4;
	arcade_pkg::group4_t coin;
	arcade_pkg::group4_t service;
	logic ce_main;
	logic ce_pix;
	arcade_pkg::color_out_t vga_r;
	arcade_pkg::color_out_t vga_g;
	arcade_pkg::color_out_t vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_de;
	int value_errors;
	int other_errors;
	int check_count;
	int stall_errors = 0;
	logic [15:0] lfsr_state = 16'd8463;
	row_t rows [row_count];

	core_shell i_dut (.*);
	shell_checker i_checker (.*);

	always #(clk_period / 2) clk_sys = ~clk_sys;

	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	// Random rows step the LFSR once per bit and fixed rows use the table value
	task automatic pick_bits(input int count, input logic rnd, input logic [31:0] fixed,
			output logic [31:0] value);
		value = rnd ? 32'd0 : fixed;
		for (int i = 0; rnd && i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic row_t make_row(input logic [1:0] op, input logic rnd,
			input logic [3:0] ctl, input logic [15:0] index, input logic [26:0] addr,
			input logic [15:0] data);
		return '{op: op, rnd: rnd, ctl: ctl, index: index, addr: addr, data: data};
	endfunction

	task automatic apply_row(input row_t row);
		logic [31:0] bits;
		int waited;
		@(posedge clk_sys);
		if (row.op == op_dl) begin
			download       <= row.ctl[0];
			download_wr    <= 1'b1;
			download_index <= row.index;
			download_addr  <= row.addr;
			download_data  <= row.data;
			@(posedge clk_sys);
			download_wr <= 1'b0;
		end else if (row.op == op_joy) begin
			pick_bits(32, row.rnd, 32'(row.data), bits);
			joy_0 <= bits;
			pick_bits(32, row.rnd, 32'(row.data), bits);
			joy_1 <= bits;
			pick_bits(32, row.rnd, 32'(row.data), bits);
			joy_2 <= bits;
			pick_bits(32, row.rnd, 32'(row.data), bits);
			joy_3 <= bits;
		end else if (row.op == op_pix) begin
			pick_bits(6, row.rnd, 32'(row.data[5:0]), bits);
			r_in <= bits[5:0];
			pick_bits(6, row.rnd, 32'(row.data[11:6]), bits);
			g_in <= bits[5:0];
			pick_bits(6, row.rnd, 32'({row.data[15:12], row.data[1:0]}), bits);
			b_in <= bits[5:0];
			{n_hsync, n_vsync, n_hblank, n_vblank} <= row.ctl;
			// Hold the pixel until the DUT takes it on an enable
			waited = 0;
			@(negedge clk_sys);
			while (!ce_pix && waited < row_wait) begin
				@(negedge clk_sys);
				waited++;
			end
			if (!ce_pix) begin
				$display("Pixel enable did not arrive within %0d cycles", row_wait);
				stall_errors++;
			end
			@(posedge clk_sys);
		end
	endtask

	task automatic fill_table();
		rows[0]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd0, 16'h1234);
		rows[1]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd1, 16'h0056);
		rows[2]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd2, 16'h00C3);
		// Out of range DIP addresses include one that aliases address 0
		rows[3]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd3, 16'h0099);
		rows[4]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'h100, 16'h0077);
		rows[5]  = make_row(op_dl, 1'b0, 4'h1, 16'd1, 27'd0, 16'h00F2);
		rows[6]  = make_row(op_dl, 1'b0, 4'h1, 16'd5, 27'd0, 16'h0011);
		rows[7]  = make_row(op_dl, 1'b0, 4'h1, 16'd0, 27'd0, 16'hBEEF);
		rows[8]  = make_row(op_dl, 1'b0, 4'h0, 16'd0, 27'd2, 16'h0000);
		rows[9]  = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd2, 16'h0001);
		rows[10] = make_row(op_joy, 1'b1, 4'h0, 16'd0, 27'd0, 16'h0000);
		rows[11] = make_row(op_joy, 1'b1, 4'h0, 16'd0, 27'd0, 16'h0000);
		rows[12] = make_row(op_joy, 1'b0, 4'h0, 16'd0, 27'd0, 16'h03FF);
		rows[13] = make_row(op_joy, 1'b1, 4'h0, 16'd0, 27'd0, 16'h0000);
		rows[14] = make_row(op_joy, 1'b0, 4'h0, 16'd0, 27'd0, 16'h0000);
		rows[15] = make_row(op_pix, 1'b1, 4'hF, 16'd0, 27'd0, 16'h0000);
		rows[16] = make_row(op_pix, 1'b1, 4'h3, 16'd0, 27'd0, 16'h0000);
		rows[17] = make_row(op_pix, 1'b1, 4'hD, 16'd0, 27'd0, 16'h0000);
		rows[18] = make_row(op_pix, 1'b0, 4'hE, 16'd0, 27'd0, 16'hFFFF);
		rows[19] = make_row(op_pix, 1'b1, 4'hA, 16'd0, 27'd0, 16'h0000);
		rows[20] = make_row(op_pix, 1'b0, 4'h7, 16'd0, 27'd0, 16'h0000);
		rows[21] = make_row(op_dl, 1'b0, 4'h1, 16'd254, 27'd1, 16'h00FC);
		rows[22] = make_row(op_joy, 1'b1, 4'h0, 16'd0, 27'd0, 16'h0000);
		rows[23] = make_row(op_pix, 1'b1, 4'hF, 16'd0, 27'd0, 16'h0000);
	endtask

	initial begin
		rst            <= 1'b1;
		download       <= 1'b0;
		download_wr    <= 1'b0;
		download_index <= '0;
		download_addr  <= '0;
		download_data  <= '0;
		joy_0          <= '0;
		joy_1          <= '0;
		joy_2          <= '0;
		joy_3          <= '0;
		r_in           <= '0;
		g_in           <= '0;
		b_in           <= '0;
		n_hsync        <= 1'b1;
		n_vsync        <= 1'b1;
		n_hblank       <= 1'b1;
		n_vblank       <= 1'b1;
		fill_table();
		repeat (5) @(posedge clk_sys);
		rst <= 1'b0;
		for (int i = 0; i < row_count; i++)
			apply_row(rows[i]);
		repeat (4) @(posedge clk_sys);
		// A quarter period after the edge no checker process is active
		#(clk_period / 4);
		$display("Checks: %0d, value errors: %0d, other errors: %0d",
			check_count, value_errors, other_errors + stall_errors);
		if (value_errors == 0 && other_errors == 0 && stall_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	// Bounded by the table length times the slowest row
	initial begin
		#(watchdog_cycles * clk_period);
		$display("Timeout: the stimulus table was still running after %0d cycles",
			watchdog_cycles);
		$display("Test failed");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+source
source/arcade_pkg.sv
source/download_if.sv
source/ioctl_capture.sv
source/player_inputs.sv
source/clock_enables.sv
source/video_conditioner.sv
source/core_shell.sv
testbench/shell_checker.sv
testbench/tb_core_shell.sv
